/* src/ahb_pkg.sv */
package ahb_pkg;

    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_nonseq = 2'b10;

    localparam logic [2:0] hsize_byte = 3'b000;
    localparam logic [2:0] hsize_half = 3'b001;
    localparam logic [2:0] hsize_word = 3'b010;

    // Master side of the bus. hwdata belongs to the data phase and lags
    // the other fields by one accepted transfer.
    typedef struct packed {
        logic [31:0] haddr;
        logic [ 1:0] htrans;
        logic [ 2:0] hsize;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready; // Slave hreadyout, or the muxed hready.
        logic        hresp;  // High means ERROR.
    } ahb_resp_t;

endpackage : ahb_pkg

/* src/soc_pkg.sv */
package soc_pkg;

    localparam logic [31:0] itcm_base       = 32'h0000_0000;
    localparam int          itcm_addr_width = 15; // Word address, 128 KiB.

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [ 2:0] size;  // Same coding as hsize.
        logic [31:0] wdata;
    } cmd_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } rsp_t;

endpackage : soc_pkg

/* src/cmd_ahb_master.sv */
module cmd_ahb_master (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_req,
    input  soc_pkg::cmd_t     cmd,
    output logic              cmd_ack,
    output soc_pkg::rsp_t     rsp,
    output ahb_pkg::ahb_req_t ahb_req,
    input  ahb_pkg::ahb_resp_t ahb_resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_ack
    } state_t;

    state_t      state;
    logic [ 1:0] htrans_q;
    logic [31:0] haddr_q;
    logic [ 2:0] hsize_q;
    logic        hwrite_q;
    logic [31:0] hwdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            cmd_ack  <= 1'b0;
            htrans_q <= ahb_pkg::htrans_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_req) begin
                        htrans_q <= ahb_pkg::htrans_nonseq;
                        state    <= st_addr;
                    end
                end
                st_addr: begin
                    if (ahb_resp.hready) begin // Address phase accepted.
                        htrans_q <= ahb_pkg::htrans_idle;
                        state    <= st_data;
                    end
                end
                st_data: begin
                    if (ahb_resp.hready) begin
                        cmd_ack <= 1'b1;
                        state   <= st_ack;
                    end
                end
                st_ack: begin
                    if (!cmd_req) begin // Requester has seen the result.
                        cmd_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_req) begin
            haddr_q  <= cmd.addr;
            hsize_q  <= cmd.size;
            hwrite_q <= cmd.write;
        end
        if (state == st_addr && ahb_resp.hready) begin
            hwdata_q <= cmd.wdata; // Write data follows into the data phase.
        end
        if (state == st_data && ahb_resp.hready) begin
            rsp.err   <= ahb_resp.hresp;
            rsp.rdata <= ahb_resp.hresp ? 32'h0 : ahb_resp.hrdata;
        end
    end

    always_comb begin
        ahb_req.haddr  = haddr_q;
        ahb_req.htrans = htrans_q;
        ahb_req.hsize  = hsize_q;
        ahb_req.hwrite = hwrite_q;
        ahb_req.hwdata = hwdata_q;
    end

endmodule : cmd_ahb_master

/* src/ahb_decoder.sv */
module ahb_decoder (
    input  logic               clk,
    input  logic               reset,
    input  ahb_pkg::ahb_req_t  ahb_req,
    output ahb_pkg::ahb_resp_t ahb_resp,
    output logic               itcm_sel,
    input  ahb_pkg::ahb_resp_t itcm_resp,
    output logic               hready
);

    localparam int win_lsb = soc_pkg::itcm_addr_width + 2;

    logic               def_sel;
    logic               itcm_data;
    logic               err_first;
    logic               err_second;
    ahb_pkg::ahb_resp_t def_resp;

    assign itcm_sel = ahb_req.haddr[31:win_lsb] == soc_pkg::itcm_base[31:win_lsb];
    assign def_sel  = !itcm_sel;

    // Data-phase ownership. Only real transfers claim the data phase, so an
    // idle bus falls through to the default slave, which then answers OKAY.
    always_ff @(posedge clk) begin
        if (reset) begin
            itcm_data <= 1'b0;
        end else if (hready) begin
            itcm_data <= itcm_sel && ahb_req.htrans[1];
        end
    end

    // Default slave. ERROR takes two cycles so the master can cancel the
    // next transfer before it is accepted.
    always_ff @(posedge clk) begin
        if (reset) begin
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            err_first  <= hready && def_sel && ahb_req.htrans[1];
            err_second <= err_first;
        end
    end

    always_comb begin
        def_resp.hrdata = 32'h0;
        def_resp.hready = !err_first;
        def_resp.hresp  = err_first || err_second;
    end

    always_comb begin
        if (itcm_data) begin
            ahb_resp = itcm_resp;
        end else begin
            ahb_resp = def_resp;
        end
    end

    assign hready = ahb_resp.hready;

endmodule : ahb_decoder

/* src/ahb_to_sram.sv */
module ahb_to_sram (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                hsel,
    input  logic                                hready,
    input  ahb_pkg::ahb_req_t                   ahb_req,
    output ahb_pkg::ahb_resp_t                  ahb_resp,
    input  logic [31:0]                         sram_rdata,
    output logic [soc_pkg::itcm_addr_width-1:0] sram_addr,
    output logic [3:0]                          sram_wen,
    output logic [31:0]                         sram_wdata,
    output logic                                sram_cs
);

    localparam int aw = soc_pkg::itcm_addr_width;

    logic          trans_valid;
    logic          wr_pend;
    logic [aw-1:0] dp_addr; // Word address of the last accepted transfer.
    logic [3:0]    wr_lanes;
    logic          rd_wait;

    function automatic logic [3:0] byte_lanes(input logic [2:0] size, input logic [1:0] offs);
        logic [3:0] lanes;
        case (size)
            ahb_pkg::hsize_byte: lanes = 4'b0001 << offs;
            ahb_pkg::hsize_half: lanes = offs[1] ? 4'b1100 : 4'b0011;
            ahb_pkg::hsize_word: lanes = 4'b1111;
            default:             lanes = 4'b0000; // Wider than the bus.
        endcase
        return lanes;
    endfunction

    assign trans_valid = hsel && hready && ahb_req.htrans[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_pend <= 1'b0;
            rd_wait <= 1'b0;
        end else begin
            if (hready) begin
                wr_pend <= trans_valid && ahb_req.hwrite;
            end
            // The port is busy with the write, so the read goes out a cycle late.
            rd_wait <= trans_valid && !ahb_req.hwrite && wr_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (trans_valid) begin
            dp_addr  <= ahb_req.haddr[aw+1:2];
            wr_lanes <= byte_lanes(ahb_req.hsize, ahb_req.haddr[1:0]);
        end
    end

    always_comb begin
        sram_cs    = 1'b0;
        sram_wen   = 4'b0000;
        sram_addr  = ahb_req.haddr[aw+1:2];
        sram_wdata = ahb_req.hwdata;
        if (wr_pend) begin
            sram_cs   = 1'b1;
            sram_wen  = wr_lanes;
            sram_addr = dp_addr;
        end else if (rd_wait) begin
            sram_cs   = 1'b1;
            sram_addr = dp_addr;
        end else if (trans_valid && !ahb_req.hwrite) begin
            sram_cs = 1'b1; // Read issued in the address phase.
        end
    end

    always_comb begin
        ahb_resp.hrdata = sram_rdata;
        ahb_resp.hready = !rd_wait;
        ahb_resp.hresp  = 1'b0;
    end

endmodule : ahb_to_sram

/* src/sram_itcm.sv */
module sram_itcm (
    input  logic                                clk,
    input  logic                                sram_cs,
    input  logic [3:0]                          sram_wen,
    input  logic [soc_pkg::itcm_addr_width-1:0] sram_addr,
    input  logic [31:0]                         sram_wdata,
    output logic [31:0]                         sram_rdata
);

    logic [31:0] mem [2**soc_pkg::itcm_addr_width];

    always_ff @(posedge clk) begin
        if (sram_cs) begin
            for (int i = 0; i < 4; i++) begin
                if (sram_wen[i]) begin
                    mem[sram_addr][8*i +: 8] <= sram_wdata[8*i +: 8];
                end
            end
            if (sram_wen == 4'b0000) begin
                sram_rdata <= mem[sram_addr]; // Holds until the next read.
            end
        end
    end

endmodule : sram_itcm

/* src/soc.sv */
module soc (
    input  logic          clk,
    input  logic          reset,
    input  logic          cmd_req,
    input  soc_pkg::cmd_t cmd,
    output logic          cmd_ack,
    output soc_pkg::rsp_t rsp
);

    ahb_pkg::ahb_req_t                   ahb_req;
    ahb_pkg::ahb_resp_t                  ahb_resp;
    ahb_pkg::ahb_resp_t                  itcm_resp;
    logic                                itcm_sel;
    logic                                hready;
    logic [31:0]                         itcm_rdata;
    logic [31:0]                         itcm_wdata;
    logic [soc_pkg::itcm_addr_width-1:0] itcm_addr;
    logic [3:0]                          itcm_wen;
    logic                                itcm_cs;

    cmd_ahb_master i_cmd_ahb_master (
        .clk     (clk     ),
        .reset   (reset   ),
        .cmd_req (cmd_req ),
        .cmd     (cmd     ),
        .cmd_ack (cmd_ack ),
        .rsp     (rsp     ),
        .ahb_req (ahb_req ),
        .ahb_resp(ahb_resp)
    );

    ahb_decoder i_ahb_decoder (
        .clk      (clk      ),
        .reset    (reset    ),
        .ahb_req  (ahb_req  ),
        .ahb_resp (ahb_resp ),
        .itcm_sel (itcm_sel ),
        .itcm_resp(itcm_resp),
        .hready   (hready   )
    );

    ahb_to_sram i_ahb_itcm (
        .clk       (clk       ),
        .reset     (reset     ),
        .hsel      (itcm_sel  ),
        .hready    (hready    ),
        .ahb_req   (ahb_req   ),
        .ahb_resp  (itcm_resp ),
        .sram_rdata(itcm_rdata),
        .sram_addr (itcm_addr ),
        .sram_wen  (itcm_wen  ),
        .sram_wdata(itcm_wdata),
        .sram_cs   (itcm_cs   )
    );

    sram_itcm i_sram_itcm (
        .clk       (clk       ),
        .sram_cs   (itcm_cs   ),
        .sram_wen  (itcm_wen  ),
        .sram_addr (itcm_addr ),
        .sram_wdata(itcm_wdata),
        .sram_rdata(itcm_rdata)
    );

endmodule : soc

/* bench/tb_soc.sv */
module tb_soc;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          reset_cycles = 16;
    localparam int          idle_cycles  = 10;
    localparam int          hold_cycles  = 5;
    localparam int          random_count = 64;
    localparam int          num_cmds     = 8 + 13 + 5 + 2 * random_count + 2;
    localparam int          max_cycles   = 40 * num_cmds + reset_cycles;
    localparam int          mem_bytes    = 2 ** (soc_pkg::itcm_addr_width + 2);
    localparam logic [31:0] lfsr_seed    = 32'h00daa6ff;
    localparam logic [31:0] lfsr_taps    = 32'h8020_0003;

    logic          clk;
    logic          reset;
    logic          cmd_req;
    soc_pkg::cmd_t cmd;
    logic          cmd_ack;
    soc_pkg::rsp_t rsp;

    logic [31:0] lfsr_state;
    logic [7:0]  ref_mem [mem_bytes]; // Byte image of the ITCM.
    int          cycle_count;

    soc i_soc (
        .clk    (clk    ),
        .reset  (reset  ),
        .cmd_req(cmd_req),
        .cmd    (cmd    ),
        .cmd_ack(cmd_ack),
        .rsp    (rsp    )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ lfsr_taps : state >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i]   = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // A byte goes to lane addr[1:0], a halfword to lanes 0-1 or 2-3.
    task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                               input logic [31:0] wdata);
        int base;
        int first;
        int count;
        base = int'(addr & (mem_bytes - 4));
        case (size)
            ahb_pkg::hsize_byte: begin
                first = addr[1:0];
                count = 1;
            end
            ahb_pkg::hsize_half: begin
                first = addr[1] ? 2 : 0;
                count = 2;
            end
            default: begin
                first = 0;
                count = 4;
            end
        endcase
        for (int i = first; i < first + count; i++) begin
            ref_mem[base + i] = wdata[8*i +: 8];
        end
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        int base;
        base = int'(addr & (mem_bytes - 4));
        return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    endfunction

    task automatic do_cmd(input logic [31:0] addr, input logic write, input logic [2:0] size,
                          input logic [31:0] wdata, input int hold,
                          output soc_pkg::rsp_t result);
        @(posedge clk);
        cmd     <= {addr, write, size, wdata};
        cmd_req <= 1'b1;
        @(negedge clk);
        while (cmd_ack !== 1'b1) @(negedge clk);
        result = rsp;
        repeat (hold) begin // Request held high past the acknowledge.
            @(negedge clk);
            check_value("cmd_ack", 32'd1, cmd_ack);
            check_value("rsp.rdata", result.rdata, rsp.rdata);
            check_value("rsp.err", result.err, rsp.err);
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        @(negedge clk);
        while (cmd_ack !== 1'b0) @(negedge clk);
    endtask

    task automatic write_itcm(input logic [31:0] addr, input logic [2:0] size,
                              input logic [31:0] wdata);
        soc_pkg::rsp_t result;
        do_cmd(addr, 1'b1, size, wdata, 0, result);
        check_value("rsp.err", 32'd0, result.err);
        model_write(addr, size, wdata);
    endtask

    task automatic read_and_compare(input logic [31:0] addr);
        soc_pkg::rsp_t result;
        do_cmd(addr, 1'b0, ahb_pkg::hsize_word, 32'h0, 0, result);
        check_value("rsp.err", 32'd0, result.err);
        check_value("rsp.rdata", model_word(addr), result.rdata);
    endtask

    task automatic test_reset_idle();
        repeat (idle_cycles) begin
            @(negedge clk);
            check_value("cmd_ack", 32'd0, cmd_ack);
        end
    endtask

    task automatic test_word_rw();
        logic [31:0]   addrs [4] = '{32'h0000_0000, 32'h0001_fffc, 32'h0000_8000, 32'h0000_0a5c};
        logic [31:0]   data;
        soc_pkg::rsp_t result;
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, data);
            write_itcm(addrs[i], ahb_pkg::hsize_word, data);
            do_cmd(addrs[i], 1'b0, ahb_pkg::hsize_word, 32'h0, 0, result);
            check_value("rsp.err", 32'd0, result.err);
            check_value("rsp.rdata", data, result.rdata);
        end
    endtask

    task automatic test_lanes();
        logic [31:0] base;
        logic [31:0] data;
        base = 32'h0000_0400;
        write_itcm(base, ahb_pkg::hsize_word, 32'h1122_3344);
        for (int offs = 0; offs < 4; offs++) begin
            rand_bits(32, data);
            write_itcm(base + offs, ahb_pkg::hsize_byte, data);
            read_and_compare(base);
        end
        for (int offs = 0; offs < 4; offs += 2) begin
            rand_bits(32, data);
            write_itcm(base + offs, ahb_pkg::hsize_half, data);
            read_and_compare(base);
        end
    endtask

    task automatic test_unmapped();
        soc_pkg::rsp_t result;
        write_itcm(32'h0000_1230, ahb_pkg::hsize_word, 32'hcafe_f00d);
        // Aliases the word above.
        do_cmd(32'h0002_1230, 1'b1, ahb_pkg::hsize_word, 32'h5555_aaaa, 0, result);
        check_value("rsp.err", 32'd1, result.err);
        check_value("rsp.rdata", 32'h0, result.rdata);
        do_cmd(32'h0002_1230, 1'b0, ahb_pkg::hsize_word, 32'h0, 0, result);
        check_value("rsp.err", 32'd1, result.err);
        check_value("rsp.rdata", 32'h0, result.rdata);
        do_cmd(32'h8000_0000, 1'b0, ahb_pkg::hsize_word, 32'h0, 0, result);
        check_value("rsp.err", 32'd1, result.err);
        check_value("rsp.rdata", 32'h0, result.rdata);
        read_and_compare(32'h0000_1230);
    endtask

    task automatic test_random();
        logic [31:0] addrs [random_count];
        logic [31:0] word_addr;
        logic [31:0] data;
        for (int i = 0; i < random_count; i++) begin
            rand_bits(soc_pkg::itcm_addr_width, word_addr);
            rand_bits(32, data);
            addrs[i] = word_addr << 2;
            write_itcm(addrs[i], ahb_pkg::hsize_word, data);
        end
        for (int i = 0; i < random_count; i++) begin
            read_and_compare(addrs[(i * 37 + 11) % random_count]); // Stride 37 visits every entry.
        end
    endtask

    task automatic test_ack_hold();
        logic [31:0]   data;
        soc_pkg::rsp_t result;
        rand_bits(32, data);
        do_cmd(32'h0000_2000, 1'b1, ahb_pkg::hsize_word, data, hold_cycles, result);
        check_value("rsp.err", 32'd0, result.err);
        model_write(32'h0000_2000, ahb_pkg::hsize_word, data);
        do_cmd(32'h0000_2000, 1'b0, ahb_pkg::hsize_word, 32'h0, hold_cycles, result);
        check_value("rsp.err", 32'd0, result.err);
        check_value("rsp.rdata", data, result.rdata);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the command port stopped responding.", max_cycles);
        abort_run();
    end

    initial begin
        reset      = 1'b1;
        cmd_req    = 1'b0;
        cmd        = '0;
        lfsr_state = lfsr_seed;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        test_reset_idle();
        test_word_rw();
        test_lanes();
        test_unmapped();
        test_random();
        test_ack_hold();
        $display("Test passed");
        $finish;
    end

endmodule : tb_soc

/* all.f */
src/ahb_pkg.sv
src/soc_pkg.sv
src/cmd_ahb_master.sv
src/ahb_decoder.sv
src/ahb_to_sram.sv
src/sram_itcm.sv
src/soc.sv
bench/tb_soc.sv

/* Bender.yml */
package:
  name: ahb_itcm_soc

sources:
  - src/ahb_pkg.sv
  - src/soc_pkg.sv
  - src/cmd_ahb_master.sv
  - src/ahb_decoder.sv
  - src/ahb_to_sram.sv
  - src/sram_itcm.sv
  - src/soc.sv
  - target: test
    files:
      - bench/tb_soc.sv
